//--- project.f
logic/rv_core_pkg.sv
logic/register_file.sv
logic/mem_port.sv
logic/datapath_unit.sv
logic/control_unit.sv
logic/rv_core_top.sv
tests/rv_core_properties.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/register_file.sv
  - logic/mem_port.sv
  - logic/datapath_unit.sv
  - logic/control_unit.sv
  - logic/rv_core_top.sv
  - target: simulation
    files:
      - tests/rv_core_properties.sv
      - tests/tb_rv_core.sv

//--- tests/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/1ps
module tb_rv_core;
  import rv_core_pkg::*;

  localparam int    mem_words      = 256;
  localparam xlen_t mem_limit      = 32'h0000_0400;  // Faults at and above
  localparam int    timeout_cycles = 2000;

  logic     clk;
  logic     reset;
  logic     mem_valid;
  logic     mem_ready;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  xlen_t    pc;
  logic     retire;
  logic     trap;
  cause_e   trap_cause;
  xlen_t    trap_addr_reg;

  xlen_t       mem [mem_words];
  logic [31:0] rng_state;
  logic        pending;  // Request seen, latency chosen
  int          lat;
  int          prog_idx;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          bad_requests;
  xlen_t       watch_addr;
  string       test_name;

  rv_core_top i_rv_core_top (
    .clk           (clk),
    .reset         (reset),
    .mem_valid     (mem_valid),
    .mem_ready     (mem_ready),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .pc            (pc),
    .retire        (retire),
    .trap          (trap),
    .trap_cause    (trap_cause),
    .trap_addr_reg (trap_addr_reg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic xlen_t fill_word(xlen_t addr);
    return 32'ha5a5_0000 ^ addr;
  endfunction

  function automatic xlen_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b011_0011};
  endfunction

  function automatic xlen_t addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b001_0011};
  endfunction

  function automatic xlen_t lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b000_0011};
  endfunction

  function automatic xlen_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
  endfunction

  function automatic xlen_t b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
  endfunction

  function automatic xlen_t lui(logic [4:0] rd, logic [19:0] upper);
    return {upper, rd, 7'b011_0111};
  endfunction

  function automatic xlen_t j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  // Memory model with 0 to 3 cycles of latency
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      mem_rsp   <= '0;
      pending   = 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;  // Accepted on this edge
      mem_rsp   <= '0;
    end else if (mem_valid) begin
      if (!pending) begin
        rng_state = next_random(rng_state);
        lat       = int'(rng_state[1:0]);
        pending   = 1'b1;
      end
      if (lat == 0) begin
        pending       = 1'b0;
        mem_ready     <= 1'b1;
        mem_rsp.fault <= (mem_req.addr >= mem_limit);
        mem_rsp.rdata <= (mem_req.addr < mem_limit) ? mem[mem_req.addr[9:2]] : '0;
        if (mem_req.write && mem_req.addr < mem_limit) begin
          mem[mem_req.addr[9:2]] = mem_req.wdata;
        end
      end else begin
        lat--;
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      bad_requests = 0;
    end else if (mem_valid && mem_req.addr == watch_addr) begin
      bad_requests++;
    end
  end

  task automatic check_word(string name, xlen_t actual, xlen_t expected);
    if (actual !== expected) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
      test_errors++;
    end
  endtask

  task automatic check_cause(string name, cause_e actual, cause_e expected);
    if (actual !== expected) begin
      $display("error at %0t: %s = %s, expected %s", $time, name, actual.name(),
               expected.name());
      test_errors++;
    end
  endtask

  task automatic check_mem(xlen_t addr, xlen_t expected);
    check_word($sformatf("mem[%h]", addr), mem[addr[9:2]], expected);
  endtask

  task automatic emit(xlen_t instr);
    mem[prog_idx] = instr;
    prog_idx++;
  endtask

  // Holds the core in reset and preloads the memory image
  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
    @(posedge clk);
    reset <= 1'b1;
    repeat (7) @(posedge clk);  // Eighth reset edge comes in release_reset
    @(negedge clk);
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(xlen_t'(i) << 2);
    end
    mem[trap_addr[9:2]] = j_type(21'd0, 5'd0);  // Park at the trap vector
    prog_idx   = 0;
    watch_addr = '1;
  endtask

  task automatic release_reset();
    @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_retires(int n);
    int count;
    int cycles;
    count  = 0;
    cycles = 0;
    while (count < n && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      if (retire) begin
        count++;
      end
    end
    if (count < n) begin
      $display("%s: timed out with %0d of %0d instructions retired", test_name, count, n);
      test_errors++;
    end
  endtask

  task automatic wait_trap();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      seen = trap;
    end
    if (!seen) begin
      $display("%s: timed out waiting for a trap", test_name);
      test_errors++;
    end else begin
      @(negedge clk);  // Cause, address and PC latched on the trap edge
      if (trap) begin
        $display("%s: trap stayed high for more than one cycle", test_name);
        test_errors++;
      end
    end
  endtask

  task automatic end_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s ok", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic test_arith();
    logic [11:0] ia;
    logic [11:0] ib;
    xlen_t       a;
    xlen_t       b;
    xlen_t       expect_w [9];
    start_test("arith");
    rng_state = next_random(rng_state);
    ia        = rng_state[11:0];
    ib        = rng_state[27:16];
    a         = {{20{ia[11]}}, ia};
    b         = {{20{ib[11]}}, ib};
    expect_w  = '{a, b, a + b, a - b, a & b, a | b, a ^ b,
                  ($signed(a) < $signed(b)) ? 32'd1 : 32'd0,
                  ($signed(b) < $signed(a)) ? 32'd1 : 32'd0};
    emit(addi(5'd1, 5'd0, ia));
    emit(addi(5'd2, 5'd0, ib));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));  // add
    emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));  // sub
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));  // slt x1 < x2
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));  // slt x2 < x1
    for (int i = 0; i < 9; i++) begin
      emit(s_type(12'h200 + 12'(4 * i), 5'(i + 1), 5'd0));
    end
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_retires(18);
    for (int i = 0; i < 9; i++) begin
      check_mem(32'h200 + xlen_t'(4 * i), expect_w[i]);
    end
    end_test();
  endtask

  task automatic test_load_store();
    xlen_t       preset;
    logic [11:0] imm;
    start_test("load_store");
    rng_state = next_random(rng_state);
    preset    = rng_state;
    rng_state = next_random(rng_state);
    imm       = rng_state[11:0];
    mem[32'h240 >> 2] = preset;
    emit(lw(5'd10, 5'd0, 12'h240));
    emit(addi(5'd11, 5'd10, imm));
    emit(s_type(12'h244, 5'd11, 5'd0));
    emit(addi(5'd0, 5'd0, 12'h037));  // Discarded by x0
    emit(s_type(12'h248, 5'd0, 5'd0));
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_retires(5);
    check_mem(32'h244, preset + {{20{imm[11]}}, imm});
    check_mem(32'h248, 32'h0);
    end_test();
  endtask

  task automatic test_control();
    int    a;
    int    b;
    int    c;
    xlen_t jal_addr;
    a = 5;
    b = 5;
    c = 9;
    start_test("control_flow");
    emit(addi(5'd1, 5'd0, 12'(a)));
    emit(addi(5'd2, 5'd0, 12'(b)));
    emit(addi(5'd3, 5'd0, 12'(c)));
    emit(addi(5'd5, 5'd0, 12'h011));  // Marker for executed slots
    emit(addi(5'd6, 5'd0, 12'h022));  // Marker for skipped slots
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));  // beq x1, x2
    emit(s_type(12'h200, 5'd6, 5'd0));
    emit(b_type(13'd8, 5'd3, 5'd1, 3'b000));  // beq x1, x3
    emit(s_type(12'h204, 5'd5, 5'd0));
    emit(b_type(13'd8, 5'd3, 5'd1, 3'b001));  // bne x1, x3
    emit(s_type(12'h208, 5'd6, 5'd0));
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));  // bne x1, x2
    emit(s_type(12'h20c, 5'd5, 5'd0));
    jal_addr = xlen_t'(prog_idx * 4);
    emit(j_type(21'd8, 5'd7));
    emit(s_type(12'h210, 5'd6, 5'd0));
    emit(s_type(12'h214, 5'd7, 5'd0));
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_retires(13);
    check_mem(32'h200, (a == b) ? fill_word(32'h200) : 32'h22);
    check_mem(32'h204, (a == c) ? fill_word(32'h204) : 32'h11);
    check_mem(32'h208, (a != c) ? fill_word(32'h208) : 32'h22);
    check_mem(32'h20c, (a != b) ? fill_word(32'h20c) : 32'h11);
    check_mem(32'h210, fill_word(32'h210));
    check_mem(32'h214, jal_addr + 32'd4);
    end_test();
  endtask

  task automatic test_lui();
    logic [19:0] upper;
    start_test("lui");
    rng_state = next_random(rng_state);
    upper     = rng_state[31:12];
    emit(lui(5'd1, upper));
    emit(s_type(12'h200, 5'd1, 5'd0));
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_retires(2);
    check_mem(32'h200, xlen_t'(upper) << 12);
    end_test();
  endtask

  task automatic test_misaligned();
    start_test("misaligned_load");
    watch_addr = 32'h202;
    emit(addi(5'd1, 5'd0, 12'h200));
    emit(lw(5'd2, 5'd1, 12'd2));
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_trap();
    check_cause("trap_cause", trap_cause, cause_misaligned);
    check_word("trap_addr_reg", trap_addr_reg, 32'h202);
    check_word("pc", pc, trap_addr);
    check_word("misaligned_requests", xlen_t'(bad_requests), 32'd0);
    end_test();
  endtask

  task automatic test_access_fault();
    start_test("access_fault");
    emit(lui(5'd1, 20'h00001));  // Base beyond the memory limit
    emit(addi(5'd2, 5'd0, 12'd77));
    emit(s_type(12'd8, 5'd2, 5'd1));
    emit(j_type(21'd0, 5'd0));
    release_reset();
    wait_trap();
    check_cause("trap_cause", trap_cause, cause_access_fault);
    check_word("trap_addr_reg", trap_addr_reg, 32'h0000_1008);
    check_word("pc", pc, trap_addr);
    end_test();
  endtask

  initial begin
    reset      = 1'b1;
    mem_ready  = 1'b0;
    mem_rsp    = '0;
    rng_state  = 32'he464_0b0e;
    watch_addr = '1;
    prog_idx   = 0;
    errors     = 0;
    tests_run  = 0;
    test_arith();
    test_load_store();
    test_control();
    test_lui();
    test_misaligned();
    test_access_fault();
    errors += i_rv_core_top.i_mem_port.i_rv_core_properties.failures;
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tests/rv_core_properties.sv
// Memory bus protocol checks
`timescale 1ns/1ps
module rv_core_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  mem_valid,
  input logic                  mem_ready,
  input rv_core_pkg::mem_req_t mem_req
);

  int failures = 0;  // Count of failed assertions

  // Request frozen while the memory stalls
  assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> $stable(mem_req))
    else begin
      $error("bus request changed while valid was waiting for ready");
      failures++;
    end

  assert property (@(posedge clk) reset |=> !mem_valid)
    else begin
      $error("mem_valid high after a reset cycle");
      failures++;
    end

  // Only word aligned requests reach the bus
  assert property (@(posedge clk) disable iff (reset)
    mem_valid |-> mem_req.addr[1:0] == 2'b00)
    else begin
      $error("mem_valid raised for a misaligned address");
      failures++;
    end

endmodule

bind mem_port rv_core_properties i_rv_core_properties (
  .clk       (clk),
  .reset     (reset),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .mem_req   (mem_req)
);

//--- logic/rv_core_top.sv
// RV32I multicycle core
`timescale 1ns/1ps
module rv_core_top (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  mem_valid,
  input  logic                  mem_ready,
  output rv_core_pkg::mem_req_t mem_req,
  input  rv_core_pkg::mem_rsp_t mem_rsp,
  output rv_core_pkg::xlen_t    pc,
  output logic                  retire,
  output logic                  trap,
  output rv_core_pkg::cause_e   trap_cause,
  output rv_core_pkg::xlen_t    trap_addr_reg
);
  import rv_core_pkg::*;

  dp_ctrl_t   ctrl;
  dp_status_t status;
  mem_req_t   core_req;   // Datapath side of the port
  mem_rsp_t   core_rsp;
  cause_e     mem_cause;
  logic       mem_start;
  logic       mem_done;

  control_unit i_control_unit (
    .clk       (clk),
    .reset     (reset),
    .status    (status),
    .mem_done  (mem_done),
    .mem_fault (core_rsp.fault),
    .mem_start (mem_start),
    .ctrl      (ctrl),
    .retire    (retire),
    .trap      (trap)
  );

  datapath_unit i_datapath_unit (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (ctrl),
    .mem_rsp       (core_rsp),
    .mem_cause     (mem_cause),
    .req           (core_req),
    .status        (status),
    .pc            (pc),
    .trap_cause    (trap_cause),
    .trap_addr_reg (trap_addr_reg)
  );

  mem_port i_mem_port (
    .clk       (clk),
    .reset     (reset),
    .start     (mem_start),
    .req_in    (core_req),
    .done      (mem_done),
    .rsp_out   (core_rsp),
    .cause     (mem_cause),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

endmodule

//--- logic/control_unit.sv
// Multicycle control FSM
`timescale 1ns/1ps
module control_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_core_pkg::dp_status_t status,
  input  logic                    mem_done,
  input  logic                    mem_fault,
  output logic                    mem_start,
  output rv_core_pkg::dp_ctrl_t   ctrl,
  output logic                    retire,
  output logic                    trap
);
  import rv_core_pkg::*;

  typedef enum logic [3:0] {
    st_fetch,
    st_fetch_wait,
    st_decode,
    st_execute_r,
    st_execute_i,
    st_alu_wb,
    st_mem_addr,
    st_mem_wait,
    st_load_wb,
    st_branch,
    st_jal,
    st_trap
  } state_e;

  state_e   state_q;
  state_e   state_d;
  logic     trap_data_q;  // Fault came from a data access
  imm_src_e imm_fmt;
  logic     branch_taken;

  function automatic alu_op_e alu_decode(logic [2:0] funct3, logic sub);
    alu_op_e op;
    case (funct3)
      3'b000:  op = sub ? alu_sub : alu_add;
      3'b010:  op = alu_slt;
      3'b100:  op = alu_xor;
      3'b110:  op = alu_or;
      3'b111:  op = alu_and;
      default: op = alu_add;
    endcase
    return op;
  endfunction

  always_comb begin
    case (status.opcode)
      opc_store:  imm_fmt = imm_s;
      opc_branch: imm_fmt = imm_b;
      opc_lui:    imm_fmt = imm_u;
      opc_jal:    imm_fmt = imm_j;
      default:    imm_fmt = imm_i;
    endcase
  end

  // BEQ on funct3 000, BNE otherwise
  assign branch_taken = (status.funct3 == 3'b000) ? status.zero : !status.zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q     <= st_fetch;
      trap_data_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_done) begin
        trap_data_q <= (state_q == st_mem_wait);
      end
    end
  end

  always_comb begin
    state_d      = state_q;
    ctrl         = '0;
    ctrl.imm_src = imm_fmt;
    mem_start    = 1'b0;
    retire       = 1'b0;
    trap         = 1'b0;
    case (state_q)
      st_fetch: begin
        mem_start = 1'b1;  // Address is the PC
        state_d   = st_fetch_wait;
      end
      st_fetch_wait: begin
        ctrl.src_a      = src_a_pc;
        ctrl.src_b      = src_b_four;
        ctrl.result_src = res_alu;
        if (mem_done && mem_fault) begin
          state_d = st_trap;
        end else if (mem_done) begin
          ctrl.ir_write = 1'b1;
          ctrl.pc_write = 1'b1;  // PC + 4
          state_d       = st_decode;
        end
      end
      st_decode: begin
        // Branch and jump target into the ALU output register
        ctrl.src_a         = src_a_old_pc;
        ctrl.src_b         = src_b_imm;
        ctrl.alu_out_write = 1'b1;
        case (status.opcode)
          opc_op:                state_d = st_execute_r;
          opc_op_imm, opc_lui:   state_d = st_execute_i;
          opc_load, opc_store:   state_d = st_mem_addr;
          opc_branch:            state_d = st_branch;
          opc_jal:               state_d = st_jal;
          default: begin
            retire  = 1'b1;  // Unknown opcode retires as a NOP
            state_d = st_fetch;
          end
        endcase
      end
      st_execute_r: begin
        ctrl.alu_op        = alu_decode(status.funct3, status.funct7_b5);
        ctrl.src_a         = src_a_rs1;
        ctrl.src_b         = src_b_rs2;
        ctrl.alu_out_write = 1'b1;
        state_d            = st_alu_wb;
      end
      st_execute_i: begin
        if (status.opcode == opc_lui) begin
          ctrl.alu_op = alu_add;
          ctrl.src_a  = src_a_zero;
        end else begin
          ctrl.alu_op = alu_decode(status.funct3, 1'b0);
          ctrl.src_a  = src_a_rs1;
        end
        ctrl.src_b         = src_b_imm;
        ctrl.alu_out_write = 1'b1;
        state_d            = st_alu_wb;
      end
      st_alu_wb: begin
        ctrl.result_src = res_alu_out;
        ctrl.reg_write  = 1'b1;
        retire          = 1'b1;
        state_d         = st_fetch;
      end
      st_mem_addr: begin
        // Request goes out from the live address, kept for a trap
        ctrl.src_a         = src_a_rs1;
        ctrl.src_b         = src_b_imm;
        ctrl.result_src    = res_alu;
        ctrl.adr_src       = 1'b1;
        ctrl.alu_out_write = 1'b1;
        ctrl.mem_write     = (status.opcode == opc_store);
        mem_start          = 1'b1;
        state_d            = st_mem_wait;
      end
      st_mem_wait: begin
        if (mem_done && mem_fault) begin
          state_d = st_trap;
        end else if (mem_done && status.opcode == opc_store) begin
          retire  = 1'b1;
          state_d = st_fetch;
        end else if (mem_done) begin
          state_d = st_load_wb;
        end
      end
      st_load_wb: begin
        ctrl.result_src = res_data;
        ctrl.reg_write  = 1'b1;
        retire          = 1'b1;
        state_d         = st_fetch;
      end
      st_branch: begin
        ctrl.alu_op     = alu_sub;
        ctrl.src_a      = src_a_rs1;
        ctrl.src_b      = src_b_rs2;
        ctrl.result_src = res_alu_out;
        ctrl.pc_write   = branch_taken;
        retire          = 1'b1;
        state_d         = st_fetch;
      end
      st_jal: begin
        ctrl.src_a         = src_a_old_pc;
        ctrl.src_b         = src_b_four;
        ctrl.result_src    = res_alu_out;  // Target from decode
        ctrl.pc_write      = 1'b1;
        ctrl.alu_out_write = 1'b1;  // Link value for writeback
        state_d            = st_alu_wb;
      end
      st_trap: begin
        ctrl.result_src = res_alu_out;
        ctrl.adr_src    = trap_data_q;
        ctrl.trap_take  = 1'b1;
        trap            = 1'b1;
        state_d         = st_fetch;
      end
      default: state_d = st_fetch;
    endcase
  end

endmodule

//--- logic/datapath_unit.sv
// Multicycle datapath
`timescale 1ns/1ps
module datapath_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_core_pkg::dp_ctrl_t   ctrl,
  input  rv_core_pkg::mem_rsp_t   mem_rsp,
  input  rv_core_pkg::cause_e     mem_cause,
  output rv_core_pkg::mem_req_t   req,
  output rv_core_pkg::dp_status_t status,
  output rv_core_pkg::xlen_t      pc,
  output rv_core_pkg::cause_e     trap_cause,
  output rv_core_pkg::xlen_t      trap_addr_reg
);
  import rv_core_pkg::*;

  xlen_t  pc_q;
  xlen_t  old_pc_q;
  xlen_t  ir_q;
  xlen_t  data_q;
  xlen_t  alu_out_q;
  xlen_t  trap_addr_q;
  cause_e trap_cause_q;
  xlen_t  imm;
  xlen_t  src_a;
  xlen_t  src_b;
  xlen_t  alu_result;
  xlen_t  result;
  xlen_t  rdata1;
  xlen_t  rdata2;

  register_file i_register_file (
    .clk    (clk),
    .rs1    (ir_q[19:15]),
    .rs2    (ir_q[24:20]),
    .rd     (ir_q[11:7]),
    .we     (ctrl.reg_write),
    .wdata  (result),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  always_comb begin
    case (ctrl.imm_src)
      imm_s:   imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
      imm_b:   imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
      imm_u:   imm = {ir_q[31:12], 12'b0};
      imm_j:   imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
      default: imm = {{20{ir_q[31]}}, ir_q[31:20]};
    endcase
  end

  always_comb begin
    case (ctrl.src_a)
      src_a_pc:     src_a = pc_q;
      src_a_old_pc: src_a = old_pc_q;
      src_a_rs1:    src_a = rdata1;
      default:      src_a = '0;
    endcase
    case (ctrl.src_b)
      src_b_rs2: src_b = rdata2;
      src_b_imm: src_b = imm;
      default:   src_b = 32'd4;
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      alu_sub: alu_result = src_a - src_b;
      alu_and: alu_result = src_a & src_b;
      alu_or:  alu_result = src_a | src_b;
      alu_xor: alu_result = src_a ^ src_b;
      alu_slt: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
      default: alu_result = src_a + src_b;
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      res_data: result = data_q;
      res_alu:  result = alu_result;
      default:  result = alu_out_q;
    endcase
  end

  assign req.addr  = ctrl.adr_src ? result : pc_q;
  assign req.wdata = rdata2;  // Store data straight from rs2
  assign req.write = ctrl.mem_write;

  assign status.opcode    = opcode_e'(ir_q[6:0]);
  assign status.funct3    = ir_q[14:12];
  assign status.funct7_b5 = ir_q[30];
  assign status.zero      = (alu_result == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q         <= reset_addr;
      ir_q         <= nop_instr;
      trap_cause_q <= cause_none;
      trap_addr_q  <= '0;
    end else begin
      if (ctrl.trap_take) begin
        pc_q         <= trap_addr;
        trap_cause_q <= mem_cause;
        trap_addr_q  <= req.addr;  // Address of the failed access
      end else if (ctrl.pc_write) begin
        pc_q <= result;
      end
      if (ctrl.ir_write) begin
        ir_q <= mem_rsp.rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    data_q <= mem_rsp.rdata;  // Valid in the cycle after done
    if (ctrl.ir_write) begin
      old_pc_q <= pc_q;
    end
    if (ctrl.alu_out_write) begin
      alu_out_q <= alu_result;
    end
  end

  assign pc            = pc_q;
  assign trap_cause    = trap_cause_q;
  assign trap_addr_reg = trap_addr_q;

endmodule

//--- logic/mem_port.sv
// Memory bus port
`timescale 1ns/1ps
module mem_port (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  rv_core_pkg::mem_req_t req_in,
  output logic                  done,
  output rv_core_pkg::mem_rsp_t rsp_out,
  output rv_core_pkg::cause_e   cause,
  output logic                  mem_valid,
  input  logic                  mem_ready,
  output rv_core_pkg::mem_req_t mem_req,
  input  rv_core_pkg::mem_rsp_t mem_rsp
);
  import rv_core_pkg::*;

  logic     valid_q;
  logic     misaligned_q;  // Pending misaligned completion
  logic     misaligned;
  mem_req_t req_q;
  cause_e   cause_q;

  assign misaligned = (req_in.addr[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q      <= 1'b0;
      misaligned_q <= 1'b0;
      cause_q      <= cause_none;
    end else if (start) begin
      valid_q      <= !misaligned;  // Bad address never reaches the bus
      misaligned_q <= misaligned;
      cause_q      <= misaligned ? cause_misaligned : cause_none;
    end else if (done) begin
      valid_q      <= 1'b0;
      misaligned_q <= 1'b0;
      if (valid_q && mem_rsp.fault) begin
        cause_q <= cause_access_fault;
      end
    end
  end

  // Request held stable until accepted
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= req_in;
    end
  end

  assign done          = misaligned_q | (valid_q & mem_ready);
  assign rsp_out.rdata = mem_rsp.rdata;
  assign rsp_out.fault = misaligned_q | (valid_q & mem_ready & mem_rsp.fault);
  assign cause         = cause_q;
  assign mem_valid     = valid_q;
  assign mem_req       = req_q;

endmodule

//--- logic/register_file.sv
// Integer register file
`timescale 1ns/1ps
module register_file (
  input  logic               clk,
  input  logic [4:0]         rs1,
  input  logic [4:0]         rs2,
  input  logic [4:0]         rd,
  input  logic               we,
  input  rv_core_pkg::xlen_t wdata,
  output rv_core_pkg::xlen_t rdata1,
  output rv_core_pkg::xlen_t rdata2
);
  import rv_core_pkg::*;

  xlen_t regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_core_pkg.sv
// RV32I core shared definitions
package rv_core_pkg;

  typedef logic [31:0] xlen_t;

  localparam xlen_t reset_addr = 32'h0000_0000;  // PC after reset
  localparam xlen_t trap_addr  = 32'h0000_0100;  // Trap vector
  localparam xlen_t nop_instr  = 32'h0000_0013;  // addi x0, x0, 0

  typedef enum logic [6:0] {
    opc_op     = 7'b011_0011,
    opc_op_imm = 7'b001_0011,
    opc_lui    = 7'b011_0111,
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    src_a_pc,
    src_a_old_pc,
    src_a_rs1,
    src_a_zero
  } src_a_e;

  typedef enum logic [1:0] {
    src_b_rs2,
    src_b_imm,
    src_b_four
  } src_b_e;

  typedef enum logic [1:0] {
    res_alu_out,  // Registered ALU output
    res_data,     // Load data register
    res_alu       // Live ALU result
  } result_src_e;

  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_src_e;

  typedef enum logic [1:0] {
    cause_none,
    cause_misaligned,
    cause_access_fault
  } cause_e;

  typedef struct packed {
    alu_op_e     alu_op;
    src_a_e      src_a;
    src_b_e      src_b;
    result_src_e result_src;
    imm_src_e    imm_src;
    logic        reg_write;
    logic        pc_write;
    logic        adr_src;        // Low selects PC, high selects result
    logic        ir_write;
    logic        alu_out_write;
    logic        mem_write;
    logic        trap_take;
  } dp_ctrl_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       zero;
  } dp_status_t;

  typedef struct packed {
    xlen_t addr;
    xlen_t wdata;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    xlen_t rdata;
    logic  fault;
  } mem_rsp_t;

endpackage
